/* Makefile */
# Verilator simulation of the audio panel
TOP = tb_audio_panel
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/audio_panel.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module audio_panel
   import audio_pkg::*;
(
   input  logic                  clock_27mhz,
   input  logic                  reset,
   input  logic                  button_up,        // active low
   input  logic                  button_down,      // active low
   input  logic                  codec_ready,
   input  codec_frame_t          codec_in,
   input  logic [`SAMPLE_W-1:0]  playback_sample,
   output logic [`SAMPLE_W-1:0]  capture_sample,
   output codec_frame_t          codec_out,
   output logic                  audio_reset_b,
   output logic [`VOLUME_W:0]    led,              // active low
   input  logic [`FREQ_W-1:0]    peak_freq,
   input  logic [`LEVEL_W-1:0]   peak_level,
   input  logic                  vsync,
   output hud_write_t            hud
);

   //////////////////////////////////////////////////////////////////////
   // buttons and volume
   //////////////////////////////////////////////////////////////////////

   logic                 up_clean, down_clean;
   logic [`VOLUME_W-1:0] volume;

   debounce debounce_up_i (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .noisy       (button_up),
      .clean       (up_clean)
   );

   debounce debounce_down_i (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .noisy       (button_down),
      .clean       (down_clean)
   );

   volume_control volume_control_i (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .up          (up_clean),
      .down        (down_clean),
      .volume      (volume)
   );

   assign led = ~{1'b0, volume};   // leds light on low

   //////////////////////////////////////////////////////////////////////
   // codec link and heads-up digits
   //////////////////////////////////////////////////////////////////////

   codec_link codec_link_i (
      .clock_27mhz     (clock_27mhz),
      .reset           (reset),
      .codec_ready     (codec_ready),
      .codec_in        (codec_in),
      .playback_sample (playback_sample),
      .codec_out       (codec_out),
      .capture_sample  (capture_sample),
      .audio_reset_b   (audio_reset_b)
   );

   hud_digit_writer hud_digit_writer_i (
      .clock_27mhz (clock_27mhz),
      .reset       (reset),
      .peak_freq   (peak_freq),
      .peak_level  (peak_level),
      .vsync       (vsync),
      .hud         (hud)
   );

endmodule

/* hdl/audio_pkg.sv */
`include "audio_defs.svh"

package audio_pkg;

   //////////////////////////////////////////////////////////////////////
   // codec slot words
   //////////////////////////////////////////////////////////////////////

   // one slot, seen as raw bits or as sample + pad
   typedef union packed {
      logic [`SLOT_W-1:0] raw;
      struct packed {
         logic [`SAMPLE_W-1:0]         sample;  // msb aligned
         logic [`SLOT_W-`SAMPLE_W-1:0] pad;     // low bits, zero on playback
      } field;
   } slot_word_u;

   // stereo pair as carried over the link
   typedef struct packed {
      slot_word_u left;
      slot_word_u right;
   } codec_frame_t;

   //////////////////////////////////////////////////////////////////////
   // heads-up digit write
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic       write;   // strobe
      logic [3:0] num;     // decimal digit value
      logic [3:0] blob;    // digit position on screen
   } hud_write_t;

endpackage

/* hdl/codec_link.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module codec_link
   import audio_pkg::*;
(
   input  logic                 clock_27mhz,
   input  logic                 reset,
   input  logic                 codec_ready,      // codec clock domain
   input  codec_frame_t         codec_in,
   input  logic [`SAMPLE_W-1:0] playback_sample,
   output codec_frame_t         codec_out,
   output logic [`SAMPLE_W-1:0] capture_sample,
   output logic                 audio_reset_b
);

   localparam int RST_W = $clog2(`CODEC_RESET_DELAY);
   localparam logic [RST_W-1:0] RST_LAST = RST_W'(`CODEC_RESET_DELAY - 1);

   //////////////////////////////////////////////////////////////////////
   // hold the codec in reset for a while after our own reset
   //////////////////////////////////////////////////////////////////////

   logic [RST_W-1:0] reset_count;

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         audio_reset_b <= 1'b0;
         reset_count   <= '0;
      end else if (reset_count == RST_LAST) begin
         audio_reset_b <= 1'b1;       // stays up until next reset
      end else begin
         reset_count <= reset_count + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ready level -> one cycle pulse on clock_27mhz
   //////////////////////////////////////////////////////////////////////

   logic [2:0] ready_sync;    // [1:0] synchronizer, [2] edge history
   logic       sample_ready;

   always_ff @(posedge clock_27mhz) begin
      if (reset) ready_sync <= '0;
      else       ready_sync <= {ready_sync[1:0], codec_ready};
   end

   assign sample_ready = ready_sync[1] & ~ready_sync[2];

   // playback sample goes out on both slots, pad zeroed
   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         codec_out <= '0;
      end else if (sample_ready) begin
         codec_out.left.field.sample  <= playback_sample;
         codec_out.left.field.pad     <= '0;
         codec_out.right.field.sample <= playback_sample;
         codec_out.right.field.pad    <= '0;
      end
   end

   assign capture_sample = codec_in.left.field.sample;   // left only

   ready_pulse_single_cycle: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      sample_ready |=> !sample_ready
   );

endmodule

/* hdl/debounce.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module debounce (
   input  logic clock_27mhz,
   input  logic reset,
   input  logic noisy,      // active low, straight from the pin
   output logic clean       // active high, filtered
);

   localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

   logic             level;   // button pressed
   logic [CNT_W-1:0] count;   // cycles level has disagreed with clean

   assign level = ~noisy;

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         clean <= 1'b0;
         count <= '0;
      end else if (level == clean) begin
         count <= '0;              // agrees again, start over
      end else if (count == LAST) begin
         clean <= level;           // held long enough
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // a flip only ever comes out of a full count
   clean_only_after_full_count: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      $changed(clean) |-> $past(count) == LAST
   );

endmodule

/* hdl/hud_digit_writer.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module hud_digit_writer
   import audio_pkg::*;
(
   input  logic                clock_27mhz,
   input  logic                reset,
   input  logic [`FREQ_W-1:0]  peak_freq,
   input  logic [`LEVEL_W-1:0] peak_level,
   input  logic                vsync,
   output hud_write_t          hud
);

   //////////////////////////////////////////////////////////////////////
   // binary to bcd, shift and add 3
   //////////////////////////////////////////////////////////////////////

   // four digits out, inputs never reach 10000
   function automatic logic [15:0] to_bcd(input logic [`FREQ_W-1:0] bin);
      logic [15:0] bcd;
      bcd = '0;
      for (int i = `FREQ_W - 1; i >= 0; i--) begin
         for (int d = 0; d < 4; d++) begin
            if (bcd[d*4 +: 4] >= 4'd5)
               bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
         end
         bcd = {bcd[14:0], bin[i]};   // shift next bit in
      end
      return bcd;
   endfunction

   logic [15:0] freq_bcd;     // thousands..ones
   logic [15:0] level_bcd;    // only tens and ones shown

   assign freq_bcd  = to_bcd(peak_freq);
   assign level_bcd = to_bcd(`FREQ_W'(peak_level));

   //////////////////////////////////////////////////////////////////////
   // one digit per vsync-low cycle
   //////////////////////////////////////////////////////////////////////

   logic [3:0] phase;         // wraps at 16
   hud_write_t next_hud;

   always_comb begin
      next_hud       = hud;   // num/blob hold when idle
      next_hud.write = 1'b1;
      case (phase)
         4'd1: begin
            next_hud.num  = freq_bcd[15:12];
            next_hud.blob = 4'd0;
         end
         4'd2: begin
            next_hud.num  = freq_bcd[11:8];
            next_hud.blob = 4'd1;
         end
         4'd3: begin
            next_hud.num  = freq_bcd[7:4];
            next_hud.blob = 4'd2;
         end
         4'd4: begin
            next_hud.num  = freq_bcd[3:0];
            next_hud.blob = 4'd3;
         end
         4'd5: begin
            next_hud.num  = level_bcd[7:4];
            next_hud.blob = 4'd4;
         end
         4'd6: begin
            next_hud.num  = level_bcd[3:0];
            next_hud.blob = 4'd5;
         end
         default: next_hud.write = 1'b0;
      endcase
   end

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         phase <= '0;
         hud   <= '0;
      end else if (!vsync) begin   // frozen during vsync high
         phase <= phase + 1'b1;
         hud   <= next_hud;
      end
   end

   // only six digit slots exist on screen
   hud_blob_in_range: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      hud.write |-> hud.blob <= 4'd5
   );

endmodule

/* hdl/volume_control.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module volume_control (
   input  logic                 clock_27mhz,
   input  logic                 reset,
   input  logic                 up,       // clean level
   input  logic                 down,     // clean level
   output logic [`VOLUME_W-1:0] volume
);

   localparam logic [`VOLUME_W-1:0] VOL_MAX = `VOLUME_W'(`VOLUME_MAX);

   logic up_q, down_q;        // last cycle's levels
   logic up_rise, down_rise;

   assign up_rise   = up & ~up_q;
   assign down_rise = down & ~down_q;

   always_ff @(posedge clock_27mhz) begin
      if (reset) begin
         volume <= `VOLUME_W'(`VOLUME_RESET);
         up_q   <= 1'b0;
         down_q <= 1'b0;
      end else begin
         up_q   <= up;
         down_q <= down;
         // down takes priority when both rise together
         if (down_rise) begin
            if (volume != '0) volume <= volume - 1'b1;
         end else if (up_rise && volume != VOL_MAX) begin
            volume <= volume + 1'b1;
         end
      end
   end

   // one step at a time, no wrap past the clamps
   volume_single_step: assert property (
      @(posedge clock_27mhz) disable iff (reset)
      $changed(volume) |->
         volume == $past(volume) + 1 || volume == $past(volume) - 1
   );

endmodule

/* include/audio_defs.svh */
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// button filtering
//////////////////////////////////////////////////////////////////////

`define DEBOUNCE_CYCLES 16       // stable cycles before clean flips

//////////////////////////////////////////////////////////////////////
// codec link
//////////////////////////////////////////////////////////////////////

`define CODEC_RESET_DELAY 1024   // cycles of audio_reset_b low
`define SAMPLE_W 12              // playback / capture sample
`define SLOT_W 20                // one codec slot word

//////////////////////////////////////////////////////////////////////
// volume
//////////////////////////////////////////////////////////////////////

`define VOLUME_RESET 8
`define VOLUME_MAX 31
`define VOLUME_W 5

// peak inputs for the heads-up digits
`define FREQ_W 13                // up to 8191
`define LEVEL_W 9                // up to 511

`endif

/* verif/panel_checker.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module panel_checker
   import audio_pkg::*;
(
   input  logic                 clock_27mhz,
   input  logic                 reset,
   input  logic                 button_up,
   input  logic                 button_down,
   input  logic                 codec_ready,
   input  codec_frame_t         codec_in,
   input  logic [`SAMPLE_W-1:0] playback_sample,
   input  logic [`SAMPLE_W-1:0] capture_sample,
   input  codec_frame_t         codec_out,
   input  logic                 audio_reset_b,
   input  logic [`VOLUME_W:0]   led,
   input  logic [`FREQ_W-1:0]   peak_freq,
   input  logic [`LEVEL_W-1:0]  peak_level,
   input  logic                 vsync,
   input  hud_write_t           hud,
   output int                   errors
);

   logic [1:0]         m_clean, m_clean_q;   // [1] up, [0] down
   int                 m_count [2];          // cycles level has differed
   int                 m_volume;
   int                 low_cycles;           // edges since reset fell
   logic               ready_q;
   logic [`SLOT_W-1:0] pend_slot, m_slot;
   int                 frames_seen = 0;
   int                 frames_done = 0;
   int                 pend_age;
   logic [3:0]         m_phase;
   hud_write_t         m_hud;
   int                 cap_errors = 0;
   int                 out_errors = 0;

   assign errors = cap_errors + out_errors;

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("MISMATCH %s expected %0h got %0h at %0t", name, expected, actual, $time);
      out_errors++;
   endtask

   // digit table, phase 1..4 freq thousands..ones, 5..6 level tens and ones
   function automatic hud_write_t digit_for_phase(input logic [3:0] phase, input int freq,
                                                  input int level, input hud_write_t last);
      hud_write_t w;
      w       = last;   // num and blob keep their old value when idle
      w.write = (phase >= 4'd1 && phase <= 4'd6);
      case (phase)
         4'd1:    w.num = 4'(freq / 1000);
         4'd2:    w.num = 4'(freq / 100 % 10);
         4'd3:    w.num = 4'(freq / 10 % 10);
         4'd4:    w.num = 4'(freq % 10);
         4'd5:    w.num = 4'(level / 10 % 10);
         4'd6:    w.num = 4'(level % 10);
         default: ;
      endcase
      if (w.write) w.blob = phase - 4'd1;
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // reference model, steps on the edge with inputs settled
   //////////////////////////////////////////////////////////////////////

   always @(posedge clock_27mhz) begin
      logic [1:0] level;   // button pressed
      level = {~button_up, ~button_down};
      if (capture_sample !== codec_in.left.raw[`SLOT_W-1 -: `SAMPLE_W]) begin
         $display("MISMATCH capture_sample expected %0h got %0h at %0t",
                  codec_in.left.raw[`SLOT_W-1 -: `SAMPLE_W], capture_sample, $time);
         cap_errors++;
      end
      if (reset) begin
         m_clean    = '0;
         m_clean_q  = '0;
         m_count    = '{0, 0};
         m_volume   = `VOLUME_RESET;
         low_cycles = 0;
         ready_q    = 1'b0;
         m_phase    = '0;
         m_hud      = '0;
      end else begin
         // clean rise moves volume one edge later, down wins a tie
         if (m_clean[0] && !m_clean_q[0]) begin
            if (m_volume > 0) m_volume--;
         end else if (m_clean[1] && !m_clean_q[1] && m_volume < `VOLUME_MAX) begin
            m_volume++;
         end
         m_clean_q = m_clean;
         for (int i = 0; i < 2; i++) begin
            if (level[i] == m_clean[i]) begin
               m_count[i] = 0;
            end else begin
               m_count[i] = m_count[i] + 1;
               if (m_count[i] == `DEBOUNCE_CYCLES) begin
                  m_clean[i] = level[i];   // stable long enough
                  m_count[i] = 0;
               end
            end
         end
         low_cycles++;
         if (codec_ready && !ready_q) begin   // new frame
            pend_slot = {playback_sample, {(`SLOT_W - `SAMPLE_W){1'b0}}};
            frames_seen++;
         end
         ready_q = codec_ready;
         if (!vsync) begin
            m_hud   = digit_for_phase(m_phase, peak_freq, peak_level, m_hud);
            m_phase = m_phase + 4'd1;   // wraps at 16
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // compare registered outputs mid cycle
   //////////////////////////////////////////////////////////////////////

   always @(negedge clock_27mhz) begin
      logic [`VOLUME_W:0] exp_led;
      exp_led = ~{1'b0, m_volume[`VOLUME_W-1:0]};
      if (led !== exp_led) report_mismatch("led", exp_led, led);
      // edge 1024 itself is the release point, either value is fine
      if (low_cycles != `CODEC_RESET_DELAY &&
          audio_reset_b !== (low_cycles > `CODEC_RESET_DELAY))
         report_mismatch("audio_reset_b", low_cycles > `CODEC_RESET_DELAY, audio_reset_b);
      if (hud.write !== m_hud.write) report_mismatch("hud.write", m_hud.write, hud.write);
      if (m_hud.write && hud.num !== m_hud.num) report_mismatch("hud.num", m_hud.num, hud.num);
      if (m_hud.write && hud.blob !== m_hud.blob)
         report_mismatch("hud.blob", m_hud.blob, hud.blob);
      if (reset) begin
         m_slot      = '0;
         pend_age    = 0;
         frames_done = frames_seen;
      end else if (frames_done != frames_seen) begin
         pend_age++;
         if (codec_out.left.raw === pend_slot && codec_out.right.raw === pend_slot) begin
            m_slot      = pend_slot;
            frames_done = frames_seen;
            pend_age    = 0;
         end else if (pend_age == 5) begin
            $display("codec_out did not pick up the playback sample within 5 cycles of codec_ready");
            out_errors++;
            m_slot      = pend_slot;
            frames_done = frames_seen;
            pend_age    = 0;
         end
      end else begin
         if (codec_out.left.raw !== m_slot)
            report_mismatch("codec_out.left", m_slot, codec_out.left.raw);
         if (codec_out.right.raw !== m_slot)
            report_mismatch("codec_out.right", m_slot, codec_out.right.raw);
      end
   end

endmodule

/* verif/tb_audio_panel.sv */
`timescale 1ns/1ps
`include "audio_defs.svh"

module tb_audio_panel
   import audio_pkg::*;
();

   // volume 2400, glitches ~700, frames 320, digits ~15000, plus margin
   localparam int CYCLE_LIMIT = 30000;

   logic                 clock_27mhz = 1'b0;
   logic                 reset;
   logic                 button_up, button_down;   // active low
   logic                 codec_ready;
   codec_frame_t         codec_in, codec_out;
   logic [`SAMPLE_W-1:0] playback_sample, capture_sample;
   logic                 audio_reset_b;
   logic [`VOLUME_W:0]   led;
   logic [`FREQ_W-1:0]   peak_freq;
   logic [`LEVEL_W-1:0]  peak_level;
   logic                 vsync;
   hud_write_t           hud;
   int                   errors;
   int                   cycles = 0;
   logic [31:0]          lcg_state = 32'h2f3f_dd72;

   always #50 clock_27mhz = ~clock_27mhz;   // 100 ns period

   audio_panel audio_panel_i (.*);

   panel_checker panel_checker_i (.*);

   // upper half only, low lcg bits cycle too fast
   function automatic logic [15:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clock_27mhz);
   endtask

   task automatic press_button(input logic up, input int hold);
      if (up) button_up = 1'b0;
      else    button_down = 1'b0;
      wait_cycles(hold);
      button_up   = 1'b1;
      button_down = 1'b1;
      wait_cycles(`DEBOUNCE_CYCLES + 4);
   endtask

   always @(posedge clock_27mhz) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("run stopped after %0d cycles without finishing, %0d errors", cycles, errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus, all changes right after a falling edge
   //////////////////////////////////////////////////////////////////////

   initial begin
      logic [15:0] r;
      reset           = 1'b1;
      button_up       = 1'b1;
      button_down     = 1'b1;
      codec_ready     = 1'b0;
      codec_in        = '0;
      playback_sample = '0;
      peak_freq       = '0;
      peak_level      = '0;
      vsync           = 1'b1;
      wait_cycles(10);
      reset = 1'b0;
      // first 20 presses lean down to hit 0, the rest lean up to hit 31
      for (int i = 0; i < 60; i++) begin
         r = next_random();
         press_button((i < 20) ? (r[3:0] == 4'd0) : (r[3:0] != 4'd0), `DEBOUNCE_CYCLES + 4);
      end
      for (int i = 0; i < 20; i++) begin   // short glitches
         r = next_random();
         press_button(r[15], 1 + int'(r % (`DEBOUNCE_CYCLES - 1)));
      end
      for (int i = 0; i < 40; i++) begin   // codec frames
         r = next_random();
         playback_sample = r[`SAMPLE_W-1:0];
         codec_in        = 40'({next_random(), next_random(), next_random()});
         codec_ready     = 1'b1;
         wait_cycles(4);
         codec_in    = 40'({next_random(), next_random(), next_random()});
         codec_ready = 1'b0;
         wait_cycles(4);
      end
      for (int i = 0; i < 600; i++) begin   // vsync-low stretches
         r          = next_random();
         peak_freq  = r[`FREQ_W-1:0];
         r          = next_random();
         peak_level = r[`LEVEL_W-1:0];
         vsync      = 1'b0;
         wait_cycles(1 + r[15:11]);
         vsync = 1'b1;
         r     = next_random();
         wait_cycles(1 + r[3:0]);
      end
      wait_cycles(8);
      $display("run finished after %0d cycles, %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+include
hdl/audio_pkg.sv
hdl/debounce.sv
hdl/volume_control.sv
hdl/codec_link.sv
hdl/hud_digit_writer.sv
hdl/audio_panel.sv
verif/panel_checker.sv
verif/tb_audio_panel.sv
